// ==== design/link_pkg.sv ====
package link_pkg;

   // one serial character on the line and on the byte streams
   typedef logic [7:0] byte_t;

   // command byte layout
   // bit 7 set means write, clear means read
   localparam int unsigned CMD_WR_BIT = 7;

   // address field starts at the bottom of the command byte
   localparam int unsigned CMD_ADDR_LSB = 0;

   // bit time in clocks when the top level is not overridden
   localparam int unsigned DEFAULT_CLKS_PER_BIT = 16;

   // data bits per 8N1 frame
   localparam int unsigned DATA_BITS = 8;

   // start, data and stop bits of one frame
   localparam int unsigned FRAME_BITS = DATA_BITS + 2;

endpackage

// ==== design/uart_tx.sv ====
module uart_tx #(
   parameter int unsigned CLKS_PER_BIT = 16
) (
   input  logic            clk,
   input  logic            i_rst_n,
   input  link_pkg::byte_t i_data,
   input  logic            i_valid,
   output logic            o_ready,
   output logic            o_txd
);

   localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT);

   typedef logic [CNT_W-1:0] cnt_t;
   typedef logic [3:0]       bit_idx_t;
   typedef logic [link_pkg::FRAME_BITS-1:0] frame_t;

   logic     busy_q;
   cnt_t     cnt_q;
   bit_idx_t bit_q;
   frame_t   shift_q;
   logic     txd_q;

   logic     take;
   logic     bit_end;

   assign o_ready = !busy_q;
   assign o_txd   = txd_q;
   assign take    = i_valid && !busy_q;
   assign bit_end = (cnt_q == cnt_t'(CLKS_PER_BIT - 1));

   // frame sequencing, line driven from a flop
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
         bit_q  <= '0;
         txd_q  <= 1'b1;
      end else if (take) begin
         busy_q <= 1'b1;
         cnt_q  <= '0;
         bit_q  <= '0;
         txd_q  <= 1'b0;
      end else if (busy_q) begin
         if (bit_end) begin
            cnt_q <= '0;
            if (bit_q == bit_idx_t'(link_pkg::FRAME_BITS - 1)) begin
               // stop bit done, line back to idle
               busy_q <= 1'b0;
               txd_q  <= 1'b1;
            end else begin
               bit_q <= bit_q + 1'b1;
               txd_q <= shift_q[1];
            end
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // stop, data lsb first, start
   always_ff @(posedge clk) begin
      if (take) begin
         shift_q <= {1'b1, i_data, 1'b0};
      end else if (busy_q && bit_end) begin
         shift_q <= {1'b1, shift_q[link_pkg::FRAME_BITS-1:1]};
      end
   end

endmodule

// ==== design/uart_rx.sv ====
module uart_rx #(
   parameter int unsigned CLKS_PER_BIT = 16
) (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_rxd,
   input  logic            i_ready,
   output link_pkg::byte_t o_data,
   output logic            o_valid,
   output logic            o_frame_err
);

   localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT);

   typedef logic [CNT_W-1:0] cnt_t;
   typedef logic [2:0]       bit_idx_t;

   typedef enum logic [2:0] {
      S_IDLE,
      S_START,
      S_DATA,
      S_STOP,
      S_HOLD
   } rx_state_t;

   rx_state_t       state_q;
   cnt_t            cnt_q;
   bit_idx_t        bit_q;
   link_pkg::byte_t shift_q;
   logic            rxd_meta_q;
   logic            rxd_q;
   logic            valid_q;
   logic            frame_err_q;

   logic            half_end;
   logic            bit_end;

   assign half_end    = (cnt_q == cnt_t'(CLKS_PER_BIT / 2 - 1));
   assign bit_end     = (cnt_q == cnt_t'(CLKS_PER_BIT - 1));
   assign o_valid     = valid_q;
   assign o_frame_err = frame_err_q;

   // line idles high
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         rxd_meta_q <= 1'b1;
         rxd_q      <= 1'b1;
      end else begin
         rxd_meta_q <= i_rxd;
         rxd_q      <= rxd_meta_q;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q     <= S_IDLE;
         cnt_q       <= '0;
         bit_q       <= '0;
         valid_q     <= 1'b0;
         frame_err_q <= 1'b0;
      end else begin
         frame_err_q <= 1'b0;
         if (valid_q && i_ready) begin
            valid_q <= 1'b0;
         end
         case (state_q)
            S_IDLE: begin
               cnt_q <= '0;
               if (!rxd_q) begin
                  state_q <= S_START;
               end
            end
            S_START: begin
               if (half_end) begin
                  cnt_q <= '0;
                  bit_q <= '0;
                  // glitch if the line is high again at mid start bit
                  state_q <= rxd_q ? S_IDLE : S_DATA;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            S_DATA: begin
               if (bit_end) begin
                  cnt_q <= '0;
                  bit_q <= bit_q + 1'b1;
                  if (bit_q == bit_idx_t'(link_pkg::DATA_BITS - 1)) begin
                     state_q <= S_STOP;
                  end
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            S_STOP: begin
               if (bit_end) begin
                  cnt_q <= '0;
                  if (rxd_q) begin
                     // a pending byte is overwritten
                     valid_q <= 1'b1;
                     state_q <= S_IDLE;
                  end else begin
                     frame_err_q <= 1'b1;
                     state_q     <= S_HOLD;
                  end
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            S_HOLD: begin
               // wait out a break before looking for the next start bit
               if (rxd_q) begin
                  state_q <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // lsb arrives first
   always_ff @(posedge clk) begin
      if (state_q == S_DATA && bit_end) begin
         shift_q <= {rxd_q, shift_q[link_pkg::DATA_BITS-1:1]};
      end
      if (state_q == S_STOP && bit_end && rxd_q) begin
         o_data <= shift_q;
      end
   end

endmodule

// ==== design/cmd_engine.sv ====
module cmd_engine #(
   parameter int unsigned ADDR_W = 4
) (
   input  logic            clk,
   input  logic            i_rst_n,
   input  link_pkg::byte_t i_rx_data,
   input  logic            i_rx_valid,
   output logic            o_rx_ready,
   output link_pkg::byte_t o_tx_data,
   output logic            o_tx_valid,
   input  logic            i_tx_ready
);

   localparam int unsigned DEPTH = 1 << ADDR_W;

   typedef logic [ADDR_W-1:0] addr_t;

   typedef enum logic [1:0] {
      S_WAIT_CMD,
      S_WAIT_DATA,
      S_RESPOND
   } eng_state_t;

   eng_state_t      state_q;
   addr_t           addr_q;
   link_pkg::byte_t resp_q;
   link_pkg::byte_t regs_q [DEPTH];

   logic            rx_take;
   logic            cmd_is_wr;
   addr_t           cmd_addr;

   // no new byte while a response is pending
   assign o_rx_ready = (state_q != S_RESPOND);
   assign o_tx_valid = (state_q == S_RESPOND);
   assign o_tx_data  = resp_q;

   assign rx_take   = i_rx_valid && o_rx_ready;
   assign cmd_is_wr = i_rx_data[link_pkg::CMD_WR_BIT];
   assign cmd_addr  = i_rx_data[link_pkg::CMD_ADDR_LSB +: ADDR_W];

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= S_WAIT_CMD;
         addr_q  <= '0;
      end else begin
         case (state_q)
            S_WAIT_CMD: begin
               if (rx_take) begin
                  addr_q  <= cmd_addr;
                  state_q <= cmd_is_wr ? S_WAIT_DATA : S_RESPOND;
               end
            end
            S_WAIT_DATA: begin
               if (rx_take) begin
                  state_q <= S_RESPOND;
               end
            end
            S_RESPOND: begin
               // held until the transmitter takes it
               if (i_tx_ready) begin
                  state_q <= S_WAIT_CMD;
               end
            end
            default: state_q <= S_WAIT_CMD;
         endcase
      end
   end

   // register file, cleared on reset
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            regs_q[i] <= '0;
         end
      end else if (state_q == S_WAIT_DATA && rx_take) begin
         regs_q[addr_q] <= i_rx_data;
      end
   end

   // response byte
   // read gives the stored value, write echoes the data
   always_ff @(posedge clk) begin
      if (rx_take) begin
         if (state_q == S_WAIT_CMD && !cmd_is_wr) begin
            resp_q <= regs_q[cmd_addr];
         end else if (state_q == S_WAIT_DATA) begin
            resp_q <= i_rx_data;
         end
      end
   end

endmodule

// ==== design/serial_mem_top.sv ====
module serial_mem_top #(
   parameter int unsigned CLKS_PER_BIT = link_pkg::DEFAULT_CLKS_PER_BIT,
   parameter int unsigned ADDR_W       = 4
) (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_rxd,
   output logic o_txd,
   output logic o_frame_err
);

   // receive stream
   link_pkg::byte_t rx_data;
   logic            rx_valid;
   logic            rx_ready;

   // transmit stream
   link_pkg::byte_t tx_data;
   logic            tx_valid;
   logic            tx_ready;

   uart_rx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) uart_rx_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_rxd      (i_rxd),
      .i_ready    (rx_ready),
      .o_data     (rx_data),
      .o_valid    (rx_valid),
      .o_frame_err(o_frame_err)
   );

   cmd_engine #(
      .ADDR_W(ADDR_W)
   ) cmd_engine_i (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_rx_data (rx_data),
      .i_rx_valid(rx_valid),
      .o_rx_ready(rx_ready),
      .o_tx_data (tx_data),
      .o_tx_valid(tx_valid),
      .i_tx_ready(tx_ready)
   );

   uart_tx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) uart_tx_i (
      .clk    (clk),
      .i_rst_n(i_rst_n),
      .i_data (tx_data),
      .i_valid(tx_valid),
      .o_ready(tx_ready),
      .o_txd  (o_txd)
   );

endmodule

// ==== tb/serial_mem_tb.sv ====
module serial_mem_tb;

   localparam int CPB        = 8;
   localparam int CLK_PERIOD = 20;
   localparam int FRAME_TIME = 10 * CPB * CLK_PERIOD;
   // frames and idle windows over all tests rounded up
   localparam int FRAME_COUNT = 132;
   localparam int TIMEOUT     = FRAME_COUNT * FRAME_TIME + 10 * FRAME_TIME;

   logic clk;
   logic i_rst_n;
   logic i_rxd;
   logic o_txd;
   logic o_frame_err;

   link_pkg::byte_t ref_mem [16];
   integer          seed;

   serial_mem_top #(
      .CLKS_PER_BIT(CPB),
      .ADDR_W      (4)
   ) serial_mem_top_i (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_rxd      (i_rxd),
      .o_txd      (o_txd),
      .o_frame_err(o_frame_err)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check_byte(input string what, input link_pkg::byte_t exp,
                             input link_pkg::byte_t got);
      assert (got === exp) else fail_run($sformatf(
         "MISMATCH at %0t: %s expected 0x%02h got 0x%02h", $time, what, exp, got));
   endtask

   task automatic compare_count(input string what, input int exp, input int got);
      assert (got == exp) else fail_run($sformatf(
         "MISMATCH at %0t: %s expected %0d got %0d", $time, what, exp, got));
   endtask

   // holds one bit time on the line from just after a rising edge
   task automatic drive_bit(input logic value);
      i_rxd = value;
      repeat (CPB) @(posedge clk);
      #2;
   endtask

   task automatic send_byte(input link_pkg::byte_t data, input bit bad_stop);
      int i;
      drive_bit(1'b0);
      for (i = 0; i < 8; i++) begin
         drive_bit(data[i]);
      end
      drive_bit(!bad_stop);
      i_rxd = 1'b1;
   endtask

   task automatic recv_byte(output link_pkg::byte_t data);
      int  i;
      int  waited;
      logic seen;
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < 4 * CPB) begin
         @(posedge clk);
         #2;
         seen   = !o_txd;
         waited = waited + 1;
      end
      assert (seen) else fail_run("no response start bit appeared on o_txd");
      // middle of the start bit
      repeat (CPB / 2) @(posedge clk);
      #2;
      assert (!o_txd) else fail_run("response start bit did not last to mid-bit");
      for (i = 0; i < 8; i++) begin
         repeat (CPB) @(posedge clk);
         #2;
         data[i] = o_txd;
      end
      repeat (CPB) @(posedge clk);
      #2;
      assert (o_txd) else fail_run("response stop bit was low");
      repeat (CPB / 2) @(posedge clk);
      #2;
   endtask

   // counts frame error pulses and low line samples over a window
   task automatic watch_outputs(input int cycles, output int frame_errs, output int txd_lows);
      int i;
      frame_errs = 0;
      txd_lows   = 0;
      for (i = 0; i < cycles; i++) begin
         @(posedge clk);
         #2;
         if (o_frame_err) frame_errs = frame_errs + 1;
         if (!o_txd) txd_lows = txd_lows + 1;
      end
   endtask

   task automatic pulse_rxd_low(input int cycles);
      i_rxd = 1'b0;
      repeat (cycles) @(posedge clk);
      #2;
      i_rxd = 1'b1;
   endtask

   task automatic write_reg(input logic [3:0] addr, input link_pkg::byte_t data);
      link_pkg::byte_t cmd;
      link_pkg::byte_t got;
      cmd = link_pkg::byte_t'(addr);
      cmd[link_pkg::CMD_WR_BIT] = 1'b1;
      send_byte(cmd, 1'b0);
      send_byte(data, 1'b0);
      recv_byte(got);
      check_byte($sformatf("write echo addr %0d", addr), data, got);
      ref_mem[addr] = data;
   endtask

   task automatic read_reg(input logic [3:0] addr);
      link_pkg::byte_t cmd;
      link_pkg::byte_t got;
      // junk in bits 6:4 that the engine ignores
      cmd = {1'b0, 3'($random(seed)), addr};
      send_byte(cmd, 1'b0);
      recv_byte(got);
      check_byte($sformatf("read addr %0d", addr), ref_mem[addr], got);
   endtask

   task automatic idle_after_reset();
      int errs;
      int lows;
      watch_outputs(20 * CPB, errs, lows);
      compare_count("frame errors while idle", 0, errs);
      compare_count("low o_txd samples while idle", 0, lows);
   endtask

   task automatic reads_after_reset();
      int a;
      for (a = 0; a < 16; a++) read_reg(4'(a));
   endtask

   task automatic write_echo_all();
      int a;
      for (a = 0; a < 16; a++) write_reg(4'(a), link_pkg::byte_t'($random(seed)));
   endtask

   task automatic scrambled_readback();
      int i;
      link_pkg::byte_t first;
      first = link_pkg::byte_t'($random(seed));
      write_reg(4'd5, first);
      // inverted so only the second write can satisfy the read of address 5
      write_reg(4'd5, ~first);
      // stride 7 visits every address once
      for (i = 0; i < 16; i++) read_reg(4'((i * 7 + 3) % 16));
   endtask

   task automatic bad_stop_frame();
      int errs;
      int lows;
      fork
         send_byte(link_pkg::byte_t'($random(seed)), 1'b1);
         watch_outputs(10 * CPB + 12 * CPB, errs, lows);
      join
      compare_count("frame error pulses", 1, errs);
      compare_count("low o_txd samples after bad frame", 0, lows);
      read_reg(4'd12);
   endtask

   task automatic glitch_rejection();
      int errs;
      int lows;
      pulse_rxd_low(CPB / 2 - 1);
      watch_outputs(12 * CPB, errs, lows);
      compare_count("frame errors after glitch", 0, errs);
      compare_count("low o_txd samples after glitch", 0, lows);
      write_reg(4'd9, link_pkg::byte_t'($random(seed)));
      read_reg(4'd9);
   endtask

   initial begin
      #(TIMEOUT);
      fail_run("watchdog expired before the tests finished");
   end

   initial begin
      seed    = 71;
      i_rst_n = 1'b0;
      i_rxd   = 1'b1;
      for (int a = 0; a < 16; a++) ref_mem[a] = 8'h00;
      repeat (16) @(posedge clk);
      #2;
      i_rst_n = 1'b1;
      idle_after_reset();
      reads_after_reset();
      write_echo_all();
      scrambled_readback();
      bad_stop_frame();
      glitch_rejection();
      $display(">>> PASS");
      $finish;
   end

endmodule

// ==== sim.f ====
design/link_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/cmd_engine.sv
design/serial_mem_top.sv
tb/serial_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= serial_mem_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
